// File: logic/enigmaPkg.sv
package enigmaPkg;

    typedef logic [7:0]  letterT;
    typedef logic [25:0] oneHotT;
    typedef logic [4:0]  positionT;
    typedef logic [31:0] dataT;

    localparam int alphabetSize = 26;
    localparam int letterBase = 65;
    localparam int rotorCount = 3;

    // Register map, byte addresses
    localparam int positionsAddr = 'h0;
    localparam int letterAddr = 'h4;
    localparam int cipherAddr = 'h8;

    localparam logic [1:0] respOkay = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    // Entry i names the input contact that drives output contact i
    localparam positionT plugboardMap [alphabetSize] = '{
        4, 10, 12, 5, 11, 6, 3, 16, 21, 25, 13, 19, 14,
        22, 24, 7, 23, 20, 18, 15, 0, 8, 1, 17, 2, 9
    };

    localparam positionT rotorMaps [rotorCount][alphabetSize] = '{
        '{7, 12, 21, 17, 0, 2, 22, 20, 23, 18, 9, 25, 15,
          3, 14, 13, 11, 8, 4, 10, 6, 5, 19, 16, 24, 1},
        '{19, 4, 7, 6, 12, 17, 8, 5, 2, 0, 1, 20, 25,
          9, 14, 22, 24, 18, 15, 13, 3, 10, 21, 16, 11, 23},
        '{19, 0, 6, 1, 15, 2, 18, 3, 16, 4, 20, 5, 21,
          13, 25, 7, 24, 8, 23, 9, 22, 11, 17, 10, 14, 12}
    };

    // Pairs are symmetric, so the reflector is its own inverse
    localparam positionT reflectorMap [alphabetSize] = '{
        24, 17, 20, 7, 16, 18, 11, 3, 15, 23, 13, 6, 14,
        10, 12, 8, 4, 1, 5, 25, 2, 22, 21, 9, 0, 19
    };

    function automatic oneHotT permuteForward(input oneHotT contacts,
                                              input positionT contactMap [alphabetSize]);
        oneHotT result;
        for (int i = 0; i < alphabetSize; i++) begin
            result[i] = contacts[contactMap[i]];
        end
        return result;
    endfunction

    // Same wiring traversed from the output side
    function automatic oneHotT permuteInverse(input oneHotT contacts,
                                              input positionT contactMap [alphabetSize]);
        oneHotT result;
        result = '0;
        for (int i = 0; i < alphabetSize; i++) begin
            result[contactMap[i]] = contacts[i];
        end
        return result;
    endfunction

endpackage

// File: logic/cipherIf.sv
`timescale 1ns/1ns

interface cipherIf
    import enigmaPkg::*;
();

    // Requests from the register block
    logic                      encipher;
    letterT                    plainLetter;
    logic                      setPositions;
    positionT [rotorCount-1:0] newPositions;

    // Result and rotor state from the core
    letterT                    cipherLetter;
    positionT [rotorCount-1:0] positions;

    modport regs (
        output encipher,
        output plainLetter,
        output setPositions,
        output newPositions,
        input  cipherLetter,
        input  positions
    );

    modport core (
        input  encipher,
        input  plainLetter,
        input  setPositions,
        input  newPositions,
        output cipherLetter,
        output positions
    );

endinterface

// File: logic/enigmaRotor.sv
`timescale 1ns/1ns

module enigmaRotor
    import enigmaPkg::*;
#(
    parameter int rotorSel = 0
) (
    input  logic     load,
    input  logic     reset,
    input  logic     step,
    input  logic     setPosition,
    input  positionT startPosition,
    input  oneHotT   forwardIn,
    input  oneHotT   backwardIn,
    output oneHotT   forwardOut,
    output oneHotT   backwardOut,
    output positionT position,
    output logic     wrap
);

    localparam positionT lastPosition = positionT'(alphabetSize - 1);

    oneHotT forwardCore;
    oneHotT backwardCore;

    // Core contact i faces entry contact i + amount
    function automatic oneHotT rotateRight(input oneHotT contacts, input positionT amount);
        logic [2*alphabetSize-1:0] doubled;
        doubled = {contacts, contacts} >> amount;
        return doubled[alphabetSize-1:0];
    endfunction

    function automatic oneHotT rotateLeft(input oneHotT contacts, input positionT amount);
        logic [2*alphabetSize-1:0] doubled;
        doubled = {contacts, contacts} << amount;
        return doubled[2*alphabetSize-1:alphabetSize];
    endfunction

    assign wrap = (position == lastPosition);

    always_ff @(posedge load) begin
        if (reset) begin
            position <= '0;
        end else if (setPosition) begin
            position <= startPosition;
        end else if (step) begin
            position <= wrap ? '0 : position + 1'b1;
        end
    end

    // Offset into the wiring, permute, then undo the offset
    assign forwardCore = permuteForward(rotateRight(forwardIn, position), rotorMaps[rotorSel]);
    assign forwardOut = rotateLeft(forwardCore, position);

    // Return path goes through the wiring backwards
    assign backwardCore = permuteInverse(rotateRight(backwardIn, position), rotorMaps[rotorSel]);
    assign backwardOut = rotateLeft(backwardCore, position);

endmodule

// File: logic/scramblerCore.sv
`timescale 1ns/1ns

module scramblerCore
    import enigmaPkg::*;
(
    input logic   load,
    input logic   reset,
    cipherIf.core bus
);

    letterT                letterIndex;
    oneHotT                plainContacts;
    oneHotT                cipherContacts;
    oneHotT                forwardPath [rotorCount+1];
    oneHotT                backwardPath [rotorCount+1];
    positionT              rotorPosition [rotorCount];
    logic [rotorCount-1:0] wrap;
    logic [rotorCount-1:0] step;

    // Letter decode, anything outside A-Z leaves every contact open
    always_comb begin
        letterIndex = bus.plainLetter - letterT'(letterBase);
        for (int i = 0; i < alphabetSize; i++) begin
            plainContacts[i] = (letterIndex == letterT'(i));
        end
    end

    assign forwardPath[0] = permuteForward(plainContacts, plugboardMap);

    // A rotor steps only while every rotor below it wraps
    always_comb begin
        logic carry;
        carry = bus.encipher;
        for (int k = 0; k < rotorCount; k++) begin
            step[k] = carry;
            carry = carry & wrap[k];
        end
    end

    for (genvar k = 0; k < rotorCount; k++) begin : gRotor
        enigmaRotor #(
            .rotorSel(k)
        ) u_enigmaRotor (
            .load(load),
            .reset(reset),
            .step(step[k]),
            .setPosition(bus.setPositions),
            .startPosition(bus.newPositions[k]),
            .forwardIn(forwardPath[k]),
            .backwardIn(backwardPath[k+1]),
            .forwardOut(forwardPath[k+1]),
            .backwardOut(backwardPath[k]),
            .position(rotorPosition[k]),
            .wrap(wrap[k])
        );
    end

    // Reflector turns the signal around at the far end
    assign backwardPath[rotorCount] = permuteForward(forwardPath[rotorCount], reflectorMap);

    assign cipherContacts = permuteInverse(backwardPath[0], plugboardMap);

    always_comb begin
        for (int k = 0; k < rotorCount; k++) begin
            bus.positions[k] = rotorPosition[k];
        end
    end

    // Letter encode; no contact gives zero
    always_comb begin
        bus.cipherLetter = '0;
        for (int i = 0; i < alphabetSize; i++) begin
            if (cipherContacts[i]) begin
                bus.cipherLetter = letterT'(letterBase + i);
            end
        end
    end

endmodule

// File: logic/enigmaRegs.sv
`timescale 1ns/1ns

module enigmaRegs
    import enigmaPkg::*;
#(
    parameter int addrWidth = 4
) (
    input  logic                 load,
    input  logic                 reset,
    input  logic [addrWidth-1:0] awAddr,
    input  logic                 awValid,
    output logic                 awReady,
    input  dataT                 wData,
    input  logic                 wValid,
    output logic                 wReady,
    output logic [1:0]           bResp,
    output logic                 bValid,
    input  logic                 bReady,
    input  logic [addrWidth-1:0] arAddr,
    input  logic                 arValid,
    output logic                 arReady,
    output dataT                 rData,
    output logic [1:0]           rResp,
    output logic                 rValid,
    input  logic                 rReady,
    cipherIf.regs                bus
);

    logic   writeAccept;
    logic   readAccept;
    logic   positionsInRange;
    logic   letterInRange;
    letterT cipherReg;
    dataT   positionsWord;

    // Address and data are taken together, one write in flight
    assign writeAccept = awValid & wValid & ~bValid;
    assign awReady = writeAccept;
    assign wReady = writeAccept;

    assign bus.plainLetter = wData[7:0];

    // One byte lane per rotor
    always_comb begin
        positionsInRange = 1'b1;
        for (int k = 0; k < rotorCount; k++) begin
            bus.newPositions[k] = wData[8*k +: $bits(positionT)];
            if (wData[8*k +: $bits(positionT)] > positionT'(alphabetSize - 1)) begin
                positionsInRange = 1'b0;
            end
        end
    end

    assign letterInRange = (wData[7:0] >= letterT'(letterBase)) &&
                           (wData[7:0] < letterT'(letterBase + alphabetSize));

    assign bus.setPositions = writeAccept && (awAddr == addrWidth'(positionsAddr)) &&
                              positionsInRange;
    assign bus.encipher = writeAccept && (awAddr == addrWidth'(letterAddr)) && letterInRange;

    always_ff @(posedge load) begin
        if (reset) begin
            bValid <= 1'b0;
        end else if (writeAccept) begin
            bValid <= 1'b1;
        end else if (bReady) begin
            bValid <= 1'b0;
        end
    end

    // Rejected writes still complete, with SLVERR
    always_ff @(posedge load) begin
        if (writeAccept) begin
            bResp <= (bus.setPositions || bus.encipher) ? respOkay : respSlvErr;
        end
    end

    // Cipher letter is sampled before the rotors step
    always_ff @(posedge load) begin
        if (reset) begin
            cipherReg <= '0;
        end else if (bus.encipher) begin
            cipherReg <= bus.cipherLetter;
        end
    end

    assign readAccept = arValid & ~rValid;
    assign arReady = readAccept;

    always_comb begin
        positionsWord = '0;
        for (int k = 0; k < rotorCount; k++) begin
            positionsWord[8*k +: $bits(positionT)] = bus.positions[k];
        end
    end

    always_ff @(posedge load) begin
        if (reset) begin
            rValid <= 1'b0;
        end else if (readAccept) begin
            rValid <= 1'b1;
        end else if (rReady) begin
            rValid <= 1'b0;
        end
    end

    // Read data is held from acceptance until rReady
    always_ff @(posedge load) begin
        if (readAccept) begin
            if (arAddr == addrWidth'(positionsAddr)) begin
                rData <= positionsWord;
                rResp <= respOkay;
            end else if (arAddr == addrWidth'(cipherAddr)) begin
                rData <= dataT'(cipherReg);
                rResp <= respOkay;
            end else begin
                rData <= '0;
                rResp <= respSlvErr;
            end
        end
    end

endmodule

// File: logic/enigmaTop.sv
`timescale 1ns/1ns

module enigmaTop
    import enigmaPkg::*;
#(
    parameter int addrWidth = 4
) (
    input  logic                 load,
    input  logic                 reset,
    input  logic [addrWidth-1:0] awAddr,
    input  logic                 awValid,
    output logic                 awReady,
    input  dataT                 wData,
    input  logic                 wValid,
    output logic                 wReady,
    output logic [1:0]           bResp,
    output logic                 bValid,
    input  logic                 bReady,
    input  logic [addrWidth-1:0] arAddr,
    input  logic                 arValid,
    output logic                 arReady,
    output dataT                 rData,
    output logic [1:0]           rResp,
    output logic                 rValid,
    input  logic                 rReady
);

    cipherIf cipherBus ();

    enigmaRegs #(
        .addrWidth(addrWidth)
    ) u_enigmaRegs (
        .load(load),
        .reset(reset),
        .awAddr(awAddr),
        .awValid(awValid),
        .awReady(awReady),
        .wData(wData),
        .wValid(wValid),
        .wReady(wReady),
        .bResp(bResp),
        .bValid(bValid),
        .bReady(bReady),
        .arAddr(arAddr),
        .arValid(arValid),
        .arReady(arReady),
        .rData(rData),
        .rResp(rResp),
        .rValid(rValid),
        .rReady(rReady),
        .bus(cipherBus.regs)
    );

    scramblerCore u_scramblerCore (
        .load(load),
        .reset(reset),
        .bus(cipherBus.core)
    );

endmodule

// File: tb/enigmaTop_properties.sv
`timescale 1ns/1ns

module enigmaTop_properties
    import enigmaPkg::*;
(
    input logic       load,
    input logic       reset,
    input logic       bValid,
    input logic       bReady,
    input logic [1:0] bResp,
    input logic       rValid,
    input logic       rReady,
    input logic [1:0] rResp,
    input dataT       rData
);

    assert property (@(posedge load) disable iff (reset)
        bValid && !bReady |=> bValid)
        else $error("write response dropped before bReady");

    // Read data and response frozen while the master stalls
    assert property (@(posedge load) disable iff (reset)
        rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp))
        else $error("read response changed before rReady");

    assert property (@(posedge load) disable iff (reset)
        bValid |-> (bResp == respOkay || bResp == respSlvErr))
        else $error("illegal write response code");

    assert property (@(posedge load) disable iff (reset)
        rValid |-> (rResp == respOkay || rResp == respSlvErr))
        else $error("illegal read response code");

endmodule

bind enigmaTop enigmaTop_properties u_enigmaTopProperties (
    .load(load),
    .reset(reset),
    .bValid(bValid),
    .bReady(bReady),
    .bResp(bResp),
    .rValid(rValid),
    .rReady(rReady),
    .rResp(rResp),
    .rData(rData)
);

// File: tb/enigmaTb.sv
`timescale 1ns/1ns

module enigmaTb
    import enigmaPkg::*;
();

    localparam int addrWidth = 4;
    localparam int cyclesPerLine = 200;

    logic                 load;
    logic                 reset;
    logic [addrWidth-1:0] awAddr;
    logic                 awValid;
    logic                 awReady;
    dataT                 wData;
    logic                 wValid;
    logic                 wReady;
    logic [1:0]           bResp;
    logic                 bValid;
    logic                 bReady;
    logic [addrWidth-1:0] arAddr;
    logic                 arValid;
    logic                 arReady;
    dataT                 rData;
    logic [1:0]           rResp;
    logic                 rValid;
    logic                 rReady;

    logic [31:0] rngState;
    int          timeoutCycles;
    string       patternLines [$];
    positionT    modelPos [3];
    positionT    savedPos [3];
    dataT        modelCipher;
    dataT        readCipher;
    dataT        plainQueue [$];
    dataT        cipherQueue [$];

    enigmaTop #(
        .addrWidth(addrWidth)
    ) u_enigmaTop (
        .load(load),
        .reset(reset),
        .awAddr(awAddr),
        .awValid(awValid),
        .awReady(awReady),
        .wData(wData),
        .wValid(wValid),
        .wReady(wReady),
        .bResp(bResp),
        .bValid(bValid),
        .bReady(bReady),
        .arAddr(arAddr),
        .arValid(arValid),
        .arReady(arReady),
        .rData(rData),
        .rResp(rResp),
        .rValid(rValid),
        .rReady(rReady)
    );

    initial begin
        load = 1'b0;
        forever #10 load = ~load;
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic checkEqual(input dataT actual, input dataT expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // Random wait before the master takes a response
    task automatic stallCycles();
        int stall;
        stall = int'(nextRandom() % 32'd4);
        repeat (stall) @(posedge load);
    endtask

    task automatic axiWrite(input dataT addr, input dataT data, output logic [1:0] resp);
        @(posedge load);
        awAddr <= addr[addrWidth-1:0];
        wData <= data;
        awValid <= 1'b1;
        wValid <= 1'b1;
        do @(negedge load); while (!(awReady && wReady));
        @(posedge load);
        awValid <= 1'b0;
        wValid <= 1'b0;
        stallCycles();
        bReady <= 1'b1;
        do @(negedge load); while (!bValid);
        resp = bResp;
        @(posedge load);
        bReady <= 1'b0;
    endtask

    task automatic axiRead(input dataT addr, output dataT data, output logic [1:0] resp);
        @(posedge load);
        arAddr <= addr[addrWidth-1:0];
        arValid <= 1'b1;
        do @(negedge load); while (!arReady);
        @(posedge load);
        arValid <= 1'b0;
        stallCycles();
        rReady <= 1'b1;
        do @(negedge load); while (!rValid);
        data = rData;
        resp = rResp;
        @(posedge load);
        rReady <= 1'b0;
    endtask

    function automatic dataT packPositions(input positionT pos [3]);
        return {11'b0, pos[2], 3'b0, pos[1], 3'b0, pos[0]};
    endfunction

    // Rotor 1 always steps, carries ripple on position 25
    task automatic stepModel();
        logic carry1;
        logic carry2;
        carry1 = (modelPos[0] == 5'd25);
        carry2 = carry1 && (modelPos[1] == 5'd25);
        modelPos[0] = (modelPos[0] == 5'd25) ? 5'd0 : modelPos[0] + 5'd1;
        if (carry1) begin
            modelPos[1] = (modelPos[1] == 5'd25) ? 5'd0 : modelPos[1] + 5'd1;
        end
        if (carry2) begin
            modelPos[2] = (modelPos[2] == 5'd25) ? 5'd0 : modelPos[2] + 5'd1;
        end
    endtask

    task automatic checkState();
        dataT       data;
        logic [1:0] resp;
        axiRead(dataT'(positionsAddr), data, resp);
        checkEqual(32'(resp), 32'(respOkay), "positions read response");
        checkEqual(data, packPositions(modelPos), "rotor positions");
        axiRead(dataT'(cipherAddr), data, resp);
        checkEqual(32'(resp), 32'(respOkay), "cipher read response");
        checkEqual(data, modelCipher, "cipher register");
        readCipher = data;
    endtask

    task automatic encipherLetter(input dataT plain, input dataT expected);
        logic [1:0] resp;
        axiWrite(dataT'(letterAddr), plain, resp);
        checkEqual(32'(resp), 32'(respOkay), "letter write response");
        stepModel();
        modelCipher = expected;
        checkState();
        checkEqual(32'(readCipher == plain), 32'd0, "letter enciphered to itself");
    endtask

    task automatic writePositions(input positionT pos [3]);
        logic [1:0] resp;
        axiWrite(dataT'(positionsAddr), packPositions(pos), resp);
        checkEqual(32'(resp), 32'(respOkay), "positions write response");
        modelPos = pos;
        checkState();
    endtask

    task automatic loadPatterns();
        int    fd;
        string line;
        fd = $fopen("tb/enigmaPatterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file tb/enigmaPatterns.txt");
            $display("TEST FAILED");
            $fatal(1, "no pattern file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    patternLines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runLine(input string line);
        byte        op;
        dataT       a;
        dataT       b;
        dataT       c;
        dataT       data;
        logic [1:0] resp;
        a = '0;
        b = '0;
        c = '0;
        void'($sscanf(line, "%c %h %h %h", op, a, b, c));
        case (op)
            "W": begin
                axiWrite(a, b, resp);
                checkEqual(32'(resp), c, "write response");
                if (c == dataT'(respOkay) && a == dataT'(positionsAddr)) begin
                    modelPos[0] = b[4:0];
                    modelPos[1] = b[12:8];
                    modelPos[2] = b[20:16];
                end
                checkState();
            end
            "E": begin
                encipherLetter(a, b);
                plainQueue.push_back(a);
                cipherQueue.push_back(b);
            end
            "R": begin
                axiRead(a, data, resp);
                checkEqual(32'(resp), b, "read response");
                checkEqual(data, c, "read data");
            end
            "B": begin
                savedPos = modelPos;
                plainQueue.delete();
                cipherQueue.delete();
            end
            "X": begin
                // Same start positions must turn the cipher text back
                writePositions(savedPos);
                foreach (cipherQueue[i]) begin
                    encipherLetter(cipherQueue[i], plainQueue[i]);
                end
            end
            default: begin
                $display("Unknown pattern command in line: %s", line);
                $display("TEST FAILED");
                $fatal(1, "bad pattern line");
            end
        endcase
    endtask

    initial begin
        timeoutCycles = 0;
        wait (timeoutCycles > 0);
        repeat (timeoutCycles) @(posedge load);
        $display("Watchdog expired after %0d cycles, the DUT stopped responding",
                 timeoutCycles);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        reset = 1'b1;
        awAddr = '0;
        awValid = 1'b0;
        wData = '0;
        wValid = 1'b0;
        bReady = 1'b0;
        arAddr = '0;
        arValid = 1'b0;
        rReady = 1'b0;
        rngState = 32'h24451bcd;
        modelPos = '{default: 5'd0};
        savedPos = '{default: 5'd0};
        modelCipher = '0;
        readCipher = '0;
        loadPatterns();
        timeoutCycles = cyclesPerLine * (patternLines.size() + 1);
        repeat (3) @(posedge load);
        reset <= 1'b0;
        @(negedge load);
        checkEqual(32'({awReady, wReady, arReady, bValid, rValid}), 32'd0,
                   "handshake outputs after reset");
        foreach (patternLines[i]) begin
            runLine(patternLines[i]);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: tb/enigmaPatterns.txt
# W addr data resp | E plain cipher | R addr resp data | B mark start | X replay from mark
# All values hex, resp 0 is OKAY and 2 is SLVERR
R 0 0 0
R 8 0 0
B
E 41 54
E 42 43
E 43 4f
X
W 0 00031919 0
B
E 5a 4c
E 59 4c
X
W 4 0000005b 2
W 4 00000040 2
W 4 00000061 2
W 0 0000001a 2
W 0 00001a00 2
W 0 001f0000 2
W 8 00000041 2
W c 00000000 2
R 4 2 0
R c 2 0
W 0 00000000 0
E 41 54

// File: tb.f
logic/enigmaPkg.sv
logic/cipherIf.sv
logic/enigmaRotor.sv
logic/scramblerCore.sv
logic/enigmaRegs.sv
logic/enigmaTop.sv
tb/enigmaTop_properties.sv
tb/enigmaTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = enigmaTb
FILELIST = tb.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJDIR)
